// ==== hw/matrix_pkg.sv ====
package matrix_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int ADDR_W        = 32;              // HADDR width
  localparam int DATA_W        = 32;              // HWDATA width
  localparam int NUM_PORTS_DEF = 3;               // Input ports sharing the slave
  localparam int PORT_IDX_W    = 2;               // Port number width

  // ------------------------------------------------
  // Transfer types
  // ------------------------------------------------
  typedef logic [1:0] htrans_t;

  localparam htrans_t HTRANS_IDLE   = 2'b00;    // No transfer
  localparam htrans_t HTRANS_BUSY   = 2'b01;    // Burst pause
  localparam htrans_t HTRANS_NONSEQ = 2'b10;    // First beat
  localparam htrans_t HTRANS_SEQ    = 2'b11;    // Burst continuation

  typedef logic [PORT_IDX_W-1:0] port_idx_t;     // Input port number
  typedef logic [DATA_W-1:0]     wdata_t;        // Data phase payload

  // Address phase payload of one port
  typedef struct packed {
    logic              sel;                      // HSEL
    logic [ADDR_W-1:0] addr;                     // HADDR
    htrans_t           trans;                    // HTRANS
    logic              write;                    // HWRITE
    logic [2:0]        size;                     // HSIZE
    logic [2:0]        burst;                    // HBURST
    logic [3:0]        prot;                     // HPROT
    logic [3:0]        master;                   // HMASTER
    logic              mastlock;                 // HMASTLOCK
  } addr_ctrl_t;

endpackage

// ==== hw/arb_if.sv ====
`timescale 1ns/10ps

interface arb_if;

  logic                  sel;                    // Selected port HSEL
  matrix_pkg::htrans_t   trans;                  // Selected port HTRANS
  logic                  mastlock;               // Selected port HMASTLOCK
  logic                  hready_mux;             // Transfer done on shared slave
  matrix_pkg::port_idx_t addr_port;              // Address phase owner
  logic                  no_port;                // No owner this phase

  // Arbiter side
  modport arb (
    input  sel, trans, mastlock, hready_mux,
    output addr_port, no_port
  );

  // Data phase tracking and ready generation
  modport dphase (
    input  sel, addr_port, no_port,
    output hready_mux
  );

  // Stage top level
  modport top (
    output sel, trans, mastlock,
    input  addr_port, no_port, hready_mux
  );

endinterface

// ==== hw/port_mux.sv ====
`timescale 1ns/10ps

module port_mux #(
  parameter int  NUM_PORTS = matrix_pkg::NUM_PORTS_DEF,
  parameter type payload_t = logic
) (
  input  payload_t              i_payload [NUM_PORTS],   // Per-port payloads
  input  matrix_pkg::port_idx_t i_port,                  // Chosen port
  input  logic                  i_none,                  // Nothing chosen
  output payload_t              o_payload,               // Chosen payload
  output logic [NUM_PORTS-1:0]  o_onehot                 // Chosen port decode
);

  // ------------------------------------------------
  // Selection
  // ------------------------------------------------
  always_comb
  begin
    o_payload = '0;                              // Zero when idle
    o_onehot  = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (!i_none && int'(i_port) == p)
      begin
        o_payload   = i_payload[p];              // Route chosen port
        o_onehot[p] = 1'b1;
      end
    end
  end

  // Out of range port numbers fall through to the zero default

endmodule

// ==== hw/output_arb.sv ====
`timescale 1ns/10ps

module output_arb #(
  parameter int NUM_PORTS = matrix_pkg::NUM_PORTS_DEF
) (
  input  logic                 HCLK,             // AHB clock
  input  logic                 HRESETn,          // Sync reset
  input  logic [NUM_PORTS-1:0] i_held_tran,      // Held transfer per port
  input  logic [NUM_PORTS-1:0] i_hsel,           // Slave select per port
  arb_if.arb                   bus               // Muxed bus view and grant
);

  logic [NUM_PORTS-1:0]  req;                    // Qualified requests
  matrix_pkg::port_idx_t addr_port_q;            // Grant and last owner
  matrix_pkg::port_idx_t next_port;              // Pre-registered grant
  logic                  no_port_q;              // No owner
  logic                  next_none;              // Pre-registered no_port
  logic                  lock_q;                 // Locked sequence in progress
  logic                  next_lock;              // Pre-registered lock
  logic                  lock_arb;               // Mastlock masked by select
  logic                  burst_hold;             // Owner mid burst

  // ------------------------------------------------
  // Request qualification and hold rules
  // ------------------------------------------------
  assign req = i_held_tran & i_hsel;             // One AND per port

  // Locked master keeps the port even while it deselects this slave
  assign lock_arb = bus.mastlock & (lock_q | bus.sel);

  assign burst_hold = !no_port_q && bus.sel &&
                      (bus.trans == matrix_pkg::HTRANS_SEQ ||
                       bus.trans == matrix_pkg::HTRANS_BUSY);   // SEQ or BUSY beat

  // ------------------------------------------------
  // Next grant
  // ------------------------------------------------
  always_comb
  begin : p_next_grant
    int idx;                                     // Candidate port
    idx       = 0;
    next_port = addr_port_q;                     // Default keeps pointer
    next_none = 1'b1;
    if (!no_port_q && (lock_arb || burst_hold))
    begin
      next_none = 1'b0;                          // Owner keeps the bus
    end
    else
    begin
      // Cyclic scan from one past the last owner
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
        idx = (int'(addr_port_q) + i) % NUM_PORTS;
        if (next_none && req[idx])
        begin
          next_port = matrix_pkg::port_idx_t'(idx);   // First requester wins
          next_none = 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------
  // Lock tracking
  // ------------------------------------------------
  always_comb
  begin
    next_lock = lock_q;                          // Hold by default
    if (bus.sel && bus.mastlock &&
        (bus.trans == matrix_pkg::HTRANS_NONSEQ || bus.trans == matrix_pkg::HTRANS_SEQ))
    begin
      next_lock = 1'b1;                          // Locked transfer started
    end
    else if (!bus.mastlock)
    begin
      next_lock = 1'b0;                          // Sequence ended
    end
  end

  // Registers advance only on accepted phases
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      addr_port_q <= matrix_pkg::port_idx_t'(NUM_PORTS - 1);  // First scan hits port 0
      no_port_q   <= 1'b1;
      lock_q      <= 1'b0;
    end
    else if (bus.hready_mux)
    begin
      addr_port_q <= next_port;
      no_port_q   <= next_none;
      lock_q      <= next_lock;
    end
  end

  assign bus.addr_port = addr_port_q;            // Registered grant
  assign bus.no_port   = no_port_q;

endmodule

// ==== hw/data_phase_ctl.sv ====
`timescale 1ns/10ps

module data_phase_ctl (
  input  logic                  HCLK,            // AHB clock
  input  logic                  HRESETn,         // Sync reset
  input  logic                  i_hreadyout,     // Slave ready
  arb_if.dphase                 bus,             // Grant in, ready out
  output matrix_pkg::port_idx_t o_data_port,     // Data phase owner
  output logic                  o_data_none      // No data phase owner
);

  logic slave_sel_q;                             // Slave selected in data phase

  // ------------------------------------------------
  // Data phase registers
  // ------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_data_port <= '0;
      o_data_none <= 1'b1;                       // HWDATA zero after reset
      slave_sel_q <= 1'b0;
    end
    else if (bus.hready_mux)
    begin
      o_data_port <= bus.addr_port;              // Follow accepted grant
      o_data_none <= bus.no_port;
      slave_sel_q <= bus.sel;                    // Selected sel
    end
  end

  // ------------------------------------------------
  // Ready generation
  // ------------------------------------------------
  // The slave only paces the stage when it owns the data phase;
  // otherwise the previous transfer is complete and the stage
  // stays ready for the next address phase
  assign bus.hready_mux = slave_sel_q ? i_hreadyout : 1'b1;

endmodule

// ==== hw/output_stage.sv ====
`timescale 1ns/10ps

module output_stage #(
  parameter int NUM_PORTS = matrix_pkg::NUM_PORTS_DEF
) (
  input  logic                          HCLK,                     // AHB clock
  input  logic                          HRESETn,                  // Sync reset
  input  logic [NUM_PORTS-1:0]          i_hsel,                   // Per-port HSEL
  input  logic [NUM_PORTS-1:0]          i_held_tran,              // Held transfer
  input  logic [matrix_pkg::ADDR_W-1:0] i_haddr [NUM_PORTS],      // HADDR
  input  matrix_pkg::htrans_t           i_htrans [NUM_PORTS],     // HTRANS
  input  logic [NUM_PORTS-1:0]          i_hwrite,                 // HWRITE
  input  logic [2:0]                    i_hsize [NUM_PORTS],      // HSIZE
  input  logic [2:0]                    i_hburst [NUM_PORTS],     // HBURST
  input  logic [3:0]                    i_hprot [NUM_PORTS],      // HPROT
  input  logic [3:0]                    i_hmaster [NUM_PORTS],    // HMASTER
  input  logic [NUM_PORTS-1:0]          i_hmastlock,              // HMASTLOCK
  input  matrix_pkg::wdata_t            i_hwdata [NUM_PORTS],     // HWDATA
  input  logic                          i_hreadyout,              // Slave ready
  output logic                          o_hsel,                   // Slave select
  output logic [matrix_pkg::ADDR_W-1:0] o_haddr,                  // Address
  output matrix_pkg::htrans_t           o_htrans,                 // Transfer type
  output logic                          o_hwrite,                 // Direction
  output logic [2:0]                    o_hsize,                  // Size
  output logic [2:0]                    o_hburst,                 // Burst type
  output logic [3:0]                    o_hprot,                  // Protection
  output logic [3:0]                    o_hmaster,                // Master ID
  output logic                          o_hmastlock,              // Locked transfer
  output matrix_pkg::wdata_t            o_hwdata,                 // Write data
  output logic                          o_hready_mux,             // Transfer done
  output logic [NUM_PORTS-1:0]          o_active                  // Address owner
);

  matrix_pkg::addr_ctrl_t ac_in [NUM_PORTS];     // Packed address payloads
  matrix_pkg::addr_ctrl_t ac_sel;                // Granted payload
  matrix_pkg::port_idx_t  data_port;             // Data phase owner
  logic                   data_none;             // No data phase owner

  arb_if arb_bus ();                             // Arbiter bus view

  // ------------------------------------------------
  // Address phase path
  // ------------------------------------------------
  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      ac_in[p].sel      = i_hsel[p];
      ac_in[p].addr     = i_haddr[p];
      ac_in[p].trans    = i_htrans[p];
      ac_in[p].write    = i_hwrite[p];
      ac_in[p].size     = i_hsize[p];
      ac_in[p].burst    = i_hburst[p];
      ac_in[p].prot     = i_hprot[p];
      ac_in[p].master   = i_hmaster[p];
      ac_in[p].mastlock = i_hmastlock[p];
    end
  end

  output_arb #(.NUM_PORTS(NUM_PORTS)) u_output_arb (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_held_tran (i_held_tran),
    .i_hsel      (i_hsel),
    .bus         (arb_bus)
  );

  port_mux #(.NUM_PORTS(NUM_PORTS), .payload_t(matrix_pkg::addr_ctrl_t)) u_addr_mux (
    .i_payload (ac_in),
    .i_port    (arb_bus.addr_port),
    .i_none    (arb_bus.no_port),
    .o_payload (ac_sel),
    .o_onehot  (o_active)                        // Active flags
  );

  // Arbiter feedback from the granted port
  assign arb_bus.sel      = ac_sel.sel;
  assign arb_bus.trans    = ac_sel.trans;
  assign arb_bus.mastlock = ac_sel.mastlock;

  assign o_hsel      = ac_sel.sel;
  assign o_haddr     = ac_sel.addr;
  assign o_htrans    = ac_sel.trans;
  assign o_hwrite    = ac_sel.write;
  assign o_hsize     = ac_sel.size;
  assign o_hburst    = ac_sel.burst;
  assign o_hprot     = ac_sel.prot;
  assign o_hmaster   = ac_sel.master;
  assign o_hmastlock = ac_sel.mastlock;

  // ------------------------------------------------
  // Data phase path
  // ------------------------------------------------
  data_phase_ctl u_data_phase_ctl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hreadyout (i_hreadyout),
    .bus         (arb_bus),
    .o_data_port (data_port),
    .o_data_none (data_none)
  );

  port_mux #(.NUM_PORTS(NUM_PORTS), .payload_t(matrix_pkg::wdata_t)) u_data_mux (
    .i_payload (i_hwdata),
    .i_port    (data_port),
    .i_none    (data_none),
    .o_payload (o_hwdata),
    .o_onehot  ()                                // Decode not needed here
  );

  assign o_hready_mux = arb_bus.hready_mux;      // Shared ready

endmodule

// ==== testbench/output_stage_chk.sv ====
`timescale 1ns/10ps

module output_stage_chk #(
  parameter int NUM_PORTS = matrix_pkg::NUM_PORTS_DEF
) (
  input logic                 HCLK,             // AHB clock
  input logic                 HRESETn,          // Sync reset
  input logic [NUM_PORTS-1:0] i_active,         // Address owner flags
  input logic                 i_hready_mux,     // Shared ready
  input logic                 i_hsel            // Slave select out
);

  logic sel_dphase;                             // Slave selected in data phase

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      sel_dphase <= 1'b0;
    else if (i_hready_mux)
      sel_dphase <= i_hsel;                     // Follows accepted phases
  end

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------
  a_active_onehot : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(i_active)) else $error("o_active has more than one bit set");

  a_ready_idle : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !sel_dphase |-> i_hready_mux) else $error("o_hready_mux low with no slave selected");

  a_grant_frozen : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hready_mux |=> $stable(i_active)) else $error("Grant moved during a wait state");

endmodule

bind output_stage output_stage_chk #(.NUM_PORTS(NUM_PORTS)) u_output_stage_chk (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .i_active     (o_active),
  .i_hready_mux (o_hready_mux),
  .i_hsel       (o_hsel)
);

// ==== testbench/tb_output_stage.sv ====
`timescale 1ns/10ps

module tb_output_stage;

  localparam int NUM_PORTS   = 3;
  localparam int CLK_PERIOD  = 40;                  // ns
  localparam int RAND_CYCLES = 300;                 // Random traffic length
  localparam int TEST_CYCLES = RAND_CYCLES + 100;   // Random plus directed phases

  // Model of the arbiter state after an edge
  typedef struct packed {
    logic                  none;                    // No owner
    matrix_pkg::port_idx_t port;                    // Owner or last owner
    logic                  lock;                    // Locked sequence open
  } grant_t;

  logic                          HCLK;
  logic                          HRESETn;
  logic [NUM_PORTS-1:0]          i_hsel;
  logic [NUM_PORTS-1:0]          i_held_tran;
  logic [matrix_pkg::ADDR_W-1:0] i_haddr [NUM_PORTS];
  matrix_pkg::htrans_t           i_htrans [NUM_PORTS];
  logic [NUM_PORTS-1:0]          i_hwrite;
  logic [2:0]                    i_hsize [NUM_PORTS];
  logic [2:0]                    i_hburst [NUM_PORTS];
  logic [3:0]                    i_hprot [NUM_PORTS];
  logic [3:0]                    i_hmaster [NUM_PORTS];
  logic [NUM_PORTS-1:0]          i_hmastlock;
  matrix_pkg::wdata_t            i_hwdata [NUM_PORTS];
  logic                          i_hreadyout;
  logic                          o_hsel;
  logic [matrix_pkg::ADDR_W-1:0] o_haddr;
  matrix_pkg::htrans_t           o_htrans;
  logic                          o_hwrite;
  logic [2:0]                    o_hsize;
  logic [2:0]                    o_hburst;
  logic [3:0]                    o_hprot;
  logic [3:0]                    o_hmaster;
  logic                          o_hmastlock;
  matrix_pkg::wdata_t            o_hwdata;
  logic                          o_hready_mux;
  logic [NUM_PORTS-1:0]          o_active;

  integer                seed = 22;                 // $random seed
  int                    ctrl_errs;
  int                    data_errs;
  int                    bits_errs;
  int                    flow_errs;                 // Grants that never came
  grant_t                m_grant;                   // Model address phase state
  matrix_pkg::port_idx_t m_dport;                   // Model data phase owner
  logic                  m_dnone;
  logic                  m_ssel;                    // Model slave selected flag

  output_stage #(.NUM_PORTS(NUM_PORTS)) dut0 (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [NUM_PORTS-1:0] port_bit(input int p);
    logic [NUM_PORTS-1:0] b;
    b    = '0;
    b[p] = 1'b1;
    return b;
  endfunction

  function automatic matrix_pkg::addr_ctrl_t port_payload(input int p);
    return {i_hsel[p], i_haddr[p], i_htrans[p], i_hwrite[p], i_hsize[p], i_hburst[p],
            i_hprot[p], i_hmaster[p], i_hmastlock[p]};   // Struct field order
  endfunction

  // Grant after an accepted phase given the owner's payload or zero
  function automatic grant_t next_grant(input grant_t cur, input logic [NUM_PORTS-1:0] req,
                                        input matrix_pkg::addr_ctrl_t bus);
    grant_t nxt;
    logic   hold;
    int     p;
    nxt      = cur;
    nxt.none = 1'b1;
    if (bus.sel && bus.mastlock && (bus.trans == matrix_pkg::HTRANS_NONSEQ ||
                                    bus.trans == matrix_pkg::HTRANS_SEQ))
      nxt.lock = 1'b1;                              // Locked transfer seen
    else if (!bus.mastlock)
      nxt.lock = 1'b0;
    hold = bus.mastlock && (cur.lock || bus.sel);   // Lock hold survives a dropped sel
    hold = hold || (bus.sel && (bus.trans == matrix_pkg::HTRANS_SEQ ||
                                bus.trans == matrix_pkg::HTRANS_BUSY));
    if (!cur.none && hold)
      nxt.none = 1'b0;
    else
      for (int k = 1; k <= NUM_PORTS; k++)
      begin
        p = (int'(cur.port) + k) % NUM_PORTS;       // Rotate past last owner
        if (nxt.none && req[p])
        begin
          nxt.port = matrix_pkg::port_idx_t'(p);
          nxt.none = 1'b0;
        end
      end
    return nxt;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_ctrl(input string name, input matrix_pkg::addr_ctrl_t got,
                            input matrix_pkg::addr_ctrl_t exp);
    if (got !== exp)
    begin
      ctrl_errs++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input matrix_pkg::wdata_t got,
                            input matrix_pkg::wdata_t exp);
    if (got !== exp)
    begin
      data_errs++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [NUM_PORTS-1:0] got,
                            input logic [NUM_PORTS-1:0] exp);
    if (got !== exp)
    begin
      bits_errs++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Outputs settle between edges and the model advances once per edge
  always @(negedge HCLK)
  begin : p_compare
    matrix_pkg::addr_ctrl_t exp_ctrl;
    matrix_pkg::wdata_t     exp_data;
    logic [NUM_PORTS-1:0]   exp_active;
    logic                   exp_ready;
    exp_ctrl   = '0;
    exp_data   = '0;
    exp_active = '0;
    if (!m_grant.none)
    begin
      exp_ctrl   = port_payload(int'(m_grant.port));
      exp_active = port_bit(int'(m_grant.port));
    end
    if (!m_dnone)
      exp_data = i_hwdata[m_dport];
    exp_ready = m_ssel ? i_hreadyout : 1'b1;
    if (HRESETn)
    begin
      check_ctrl("o_haddr/o_hsel/control", {o_hsel, o_haddr, o_htrans, o_hwrite, o_hsize,
                 o_hburst, o_hprot, o_hmaster, o_hmastlock}, exp_ctrl);
      check_data("o_hwdata", o_hwdata, exp_data);
      check_bits("o_active", o_active, exp_active);
      check_bits("o_hready_mux", NUM_PORTS'(o_hready_mux), NUM_PORTS'(exp_ready));
    end
    if (!HRESETn)
    begin
      m_grant.none = 1'b1;
      m_grant.port = matrix_pkg::port_idx_t'(NUM_PORTS - 1);   // Scan begins at port 0
      m_grant.lock = 1'b0;
      m_dport      = '0;
      m_dnone      = 1'b1;
      m_ssel       = 1'b0;
    end
    else if (exp_ready)
    begin
      m_dport = m_grant.port;                       // Data phase follows grant
      m_dnone = m_grant.none;
      m_ssel  = exp_ctrl.sel;
      m_grant = next_grant(m_grant, i_held_tran & i_hsel, exp_ctrl);
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  task automatic set_port(input int p, input logic sel, input matrix_pkg::htrans_t trans,
                          input logic lock);
    logic [31:0] r;
    r = $random(seed);
    i_hsel[p]      <= sel;
    i_held_tran[p] <= sel;
    i_htrans[p]    <= trans;
    i_hmastlock[p] <= lock;
    i_hwrite[p]    <= r[0];
    i_hsize[p]     <= r[3:1];
    i_hburst[p]    <= r[6:4];
    i_hprot[p]     <= r[10:7];
    i_hmaster[p]   <= r[14:11];
    i_haddr[p]     <= $random(seed);
    i_hwdata[p]    <= $random(seed);
  endtask

  task automatic idle_all();
    for (int p = 0; p < NUM_PORTS; p++)
      set_port(p, 1'b0, matrix_pkg::HTRANS_IDLE, 1'b0);
  endtask

  task automatic wait_grant(input int p);
    int n;
    n = 0;
    do
    begin
      @(negedge HCLK);
      n++;
    end
    while (!o_active[p] && n < 8);
    if (!o_active[p])
    begin
      flow_errs++;
      $display("Port %0d never received the grant at %0t", p, $time);
    end
  endtask

  task automatic expect_owner(input int p, input int cycles);
    repeat (cycles)
    begin
      @(posedge HCLK);
      @(negedge HCLK);
      check_bits("o_active", o_active, port_bit(p));
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin : p_stimulus
    logic [31:0]          r;
    logic [NUM_PORTS-1:0] held_active;
    matrix_pkg::wdata_t   held_data;
    HRESETn     = 1'b0;
    i_hreadyout = 1'b1;
    i_hsel      = '0;
    i_held_tran = '0;
    i_hwrite    = '0;
    i_hmastlock = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      i_haddr[p]   = '0;
      i_htrans[p]  = matrix_pkg::HTRANS_IDLE;
      i_hsize[p]   = '0;
      i_hburst[p]  = '0;
      i_hprot[p]   = '0;
      i_hmaster[p] = '0;
      i_hwdata[p]  = '0;
    end
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(posedge HCLK);                                // Idle cycle shows reset state
    for (int p = 0; p < NUM_PORTS; p++)
      set_port(p, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    for (int k = 0; k < 6; k++)
    begin
      @(posedge HCLK);
      @(negedge HCLK);
      check_bits("o_active", o_active, port_bit(k % NUM_PORTS));   // 0, 1, 2, 0 ...
    end
    // Burst hold on port 0
    @(posedge HCLK);
    idle_all();
    @(posedge HCLK);
    set_port(0, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    wait_grant(0);
    @(posedge HCLK);
    set_port(0, 1'b1, matrix_pkg::HTRANS_SEQ, 1'b0);
    set_port(1, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    set_port(2, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    expect_owner(0, 2);
    @(posedge HCLK);
    set_port(0, 1'b1, matrix_pkg::HTRANS_BUSY, 1'b0);
    expect_owner(0, 2);
    // Locked sequence on port 1 with a deselect gap
    @(posedge HCLK);
    idle_all();
    @(posedge HCLK);
    set_port(1, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b1);
    wait_grant(1);
    @(posedge HCLK);
    set_port(1, 1'b0, matrix_pkg::HTRANS_IDLE, 1'b1);
    set_port(0, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    set_port(2, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    expect_owner(1, 3);
    @(posedge HCLK);
    set_port(1, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);   // Last phase with lock dropped
    @(negedge HCLK);
    check_bits("o_active", o_active, port_bit(1));
    expect_owner(2, 1);
    // Back-pressure with port 2 in the data phase
    @(posedge HCLK);
    idle_all();
    repeat (2) @(posedge HCLK);
    set_port(2, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);
    wait_grant(2);
    @(posedge HCLK);
    i_hreadyout <= 1'b0;
    set_port(0, 1'b1, matrix_pkg::HTRANS_NONSEQ, 1'b0);   // Competing request
    @(negedge HCLK);
    held_active = o_active;
    held_data   = o_hwdata;
    repeat (4)
    begin
      @(posedge HCLK);
      @(negedge HCLK);
      check_bits("o_hready_mux", NUM_PORTS'(o_hready_mux), '0);
      check_bits("o_active", o_active, held_active);
      check_data("o_hwdata", o_hwdata, held_data);
    end
    @(posedge HCLK);
    i_hreadyout <= 1'b1;
    idle_all();
    repeat (2) @(posedge HCLK);
    repeat (6)
    begin
      @(posedge HCLK);
      r = $random(seed);
      i_hreadyout <= r[0];                          // No slave selected
      @(negedge HCLK);
      check_bits("o_hready_mux", NUM_PORTS'(o_hready_mux), NUM_PORTS'(1'b1));
    end
    // Random traffic against the model
    repeat (RAND_CYCLES)
    begin
      @(posedge HCLK);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        r = $random(seed);
        set_port(p, r[0] | r[1], r[3:2], r[5:4] == 2'b00);
        i_held_tran[p] <= (r[7:6] != 2'b00);        // Held flag apart from sel
      end
      r = $random(seed);
      i_hreadyout <= (r[1:0] != 2'b00);             // Mostly ready
    end
    @(posedge HCLK);
    idle_all();
    i_hreadyout <= 1'b1;
    repeat (3) @(posedge HCLK);
    $display("Errors: ctrl %0d data %0d bits %0d flow %0d",
             ctrl_errs, data_errs, bits_errs, flow_errs);
    if (ctrl_errs + data_errs + bits_errs + flow_errs == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin : p_watchdog
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("Watchdog expired before the test sequence completed");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== compile.f ====
hw/matrix_pkg.sv
hw/arb_if.sv
hw/port_mux.sv
hw/output_arb.sv
hw/data_phase_ctl.sv
hw/output_stage.sv
testbench/output_stage_chk.sv
testbench/tb_output_stage.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the output stage testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_output_stage \
  -o sim_output_stage || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_output_stage > sim.log 2>&1 || echo "** FAIL **" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
